//--- flist.f
design/harris_pix_pkg.sv
design/harris_math_pkg.sv
design/harris_gradient.sv
design/harris_smooth.sv
design/harris_response.sv
design/harris_out_queue.sv
design/harris_top.sv
dv/harris_props.sv
dv/harris_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = harris_tb
FILELIST = flist.f
BUILD    = obj_dir
PASS_MSG = RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD)

//--- dv/harris_tb.sv
// testbench for the streaming Harris corner classifier
// sends 5x5 windows under credit flow control, checks each result in order
// against a reference model of the classification rule

module harris_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import harris_pix_pkg::*;
  import harris_math_pkg::*;

  localparam int THRESH  = 5000;
  localparam int DEPTH   = 4;
  localparam int TIMEOUT = 500;

  logic    clk = 1'b0;
  logic    arst_n;
  logic    in_valid;
  window_t in_window;
  logic    in_credit;
  logic    out_credit;
  logic    out_valid;
  result_t out_result;

  integer  seed;
  result_t exp_q [$];
  int      prod_credits;
  int      sent;
  int      received;
  int      granted;
  int      checks;
  int      errors;
  bit      consumer_on;

  harris_top #(
    .THRESH (THRESH),
    .DEPTH  (DEPTH)
  ) i_dut (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_window  (in_window),
    .in_credit  (in_credit),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  always #4 clk = ~clk;

  // ******************************
  // reference model
  // ******************************
  function automatic result_t ref_result(input window_t w);
    longint  p [5][5];
    longint  gx;
    longint  gy;
    longint  wt;
    longint  sxx;
    longint  syy;
    longint  sxy;
    longint  tr;
    longint  resp;
    longint  cmax;
    longint  cmin;
    int      y;
    int      x;
    bit      edge_hit;
    result_t res;
    for (int r = 0; r < 5; r++) begin
      for (int c = 0; c < 5; c++) begin
        p[r][c] = longint'(w[r*WIN_SIZE+c]);
      end
    end
    sxx = 0;
    syy = 0;
    sxy = 0;
    for (int i = 0; i < 3; i++) begin
      for (int j = 0; j < 3; j++) begin
        y  = i + 1;
        x  = j + 1;
        gx = (p[y-1][x+1] + 2 * p[y][x+1] + p[y+1][x+1])
           - (p[y-1][x-1] + 2 * p[y][x-1] + p[y+1][x-1]);
        gy = (p[y+1][x-1] + 2 * p[y+1][x] + p[y+1][x+1])
           - (p[y-1][x-1] + 2 * p[y-1][x] + p[y-1][x+1]);
        // 1-2-1 gaussian, doubled on the middle row and column
        wt  = ((i == 1) ? 2 : 1) * ((j == 1) ? 2 : 1);
        sxx += wt * gx * gx;
        syy += wt * gy * gy;
        sxy += wt * gx * gy;
      end
    end
    tr   = sxx + syy;
    resp = sxx * syy - sxy * sxy - ((K_NUM * tr * tr) >> K_SHIFT);
    cmax = p[2][2];
    cmin = p[2][2];
    cmax = (p[1][2] > cmax) ? p[1][2] : cmax;
    cmax = (p[3][2] > cmax) ? p[3][2] : cmax;
    cmax = (p[2][1] > cmax) ? p[2][1] : cmax;
    cmax = (p[2][3] > cmax) ? p[2][3] : cmax;
    cmin = (p[1][2] < cmin) ? p[1][2] : cmin;
    cmin = (p[3][2] < cmin) ? p[3][2] : cmin;
    cmin = (p[2][1] < cmin) ? p[2][1] : cmin;
    cmin = (p[2][3] < cmin) ? p[2][3] : cmin;
    edge_hit = (cmax - cmin >= 1) && (p[2][2] != 0);
    if (!edge_hit) begin
      res.pixel  = w[12];
      res.corner = 1'b0;
    end else if (resp > THRESH) begin
      res.pixel  = w[12];
      res.corner = 1'b1;
    end else begin
      res.pixel  = '0;
      res.corner = 1'b0;
    end
    return res;
  endfunction

  // ******************************
  // checking and run control
  // ******************************
  task automatic check(input string what, input longint got, input longint exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERR %0d ns: %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d, errors: %0d, sent: %0d, received: %0d",
             checks, errors, sent, received);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic abort_run(input string what);
    errors++;
    $display("timeout: %s", what);
    finish_run();
  endtask

  // ******************************
  // stimulus helpers
  // ******************************
  // waits for a producer credit, then drives one item for one cycle
  task automatic send_window(input window_t w);
    int waited;
    waited = 0;
    while (prod_credits == 0) begin
      @(posedge clk);
      #1;
      in_valid = 1'b0;
      waited++;
      if (waited > TIMEOUT) begin
        abort_run("no upstream credit came back for the next item");
      end
    end
    in_valid  = 1'b1;
    in_window = w;
    exp_q.push_back(ref_result(w));
    prod_credits--;
    sent++;
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic wait_drain(input string phase);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > TIMEOUT) begin
        abort_run({"results did not all come back during ", phase});
      end
    end
  endtask

  function automatic window_t flat_window(input pix_t v);
    window_t w;
    for (int k = 0; k < WIN_SIZE * WIN_SIZE; k++) begin
      w[k] = v;
    end
    return w;
  endfunction

  // bright top-left quadrant whose corner is the centre pixel
  function automatic window_t quadrant_window(input pix_t bright, input pix_t dark);
    window_t w;
    for (int r = 0; r < WIN_SIZE; r++) begin
      for (int c = 0; c < WIN_SIZE; c++) begin
        w[r*WIN_SIZE+c] = (r <= 2 && c <= 2) ? bright : dark;
      end
    end
    return w;
  endfunction

  // vertical step, the centre column belongs to the right side
  function automatic window_t step_window(input pix_t left, input pix_t right);
    window_t w;
    for (int r = 0; r < WIN_SIZE; r++) begin
      for (int c = 0; c < WIN_SIZE; c++) begin
        w[r*WIN_SIZE+c] = (c >= 2) ? right : left;
      end
    end
    return w;
  endfunction

  function automatic window_t random_window();
    window_t w;
    for (int k = 0; k < WIN_SIZE * WIN_SIZE; k++) begin
      w[k] = pix_t'($random(seed));
    end
    return w;
  endfunction

  // ******************************
  // compare process
  // ******************************
  // outputs settle mid-cycle, so results and credits are sampled on the falling edge
  always @(negedge clk) begin
    if (arst_n) begin
      if (out_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("a result (0x%0h) came out at %0d ns with no item outstanding",
                   out_result, $time);
        end else begin
          check("output result", out_result, exp_q.pop_front());
        end
        received++;
      end
      if (in_credit) begin
        prod_credits++;
      end
    end
  end

  // consumer: grants one credit per outstanding item, with random gaps
  initial begin
    bit grant;
    int gap_left;
    gap_left = 0;
    forever begin
      @(negedge clk);
      grant = 1'b0;
      if (gap_left > 0) begin
        gap_left--;
      end else if (consumer_on && arst_n && granted < sent) begin
        grant    = 1'b1;
        granted++;
        gap_left = {$random(seed)} % 4;
      end
      @(posedge clk);
      #1;
      out_credit = grant;
    end
  end

  // ******************************
  // main sequence
  // ******************************
  initial begin
    window_t w;
    int      held;
    seed         = 58;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    in_window    = '0;
    out_credit   = 1'b0;
    prod_credits = DEPTH;
    sent         = 0;
    received     = 0;
    granted      = 0;
    checks       = 0;
    errors       = 0;
    consumer_on  = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // directed cases, reference class checked against the rule first
    w = flat_window(8'd100);
    check("flat window class", ref_result(w), {8'd100, 1'b0});
    send_window(w);
    w = quadrant_window(8'd200, 8'd20);
    check("corner window class", ref_result(w), {8'd200, 1'b1});
    send_window(w);
    w = step_window(8'd20, 8'd200);
    check("step window class", ref_result(w), {8'd0, 1'b0});
    send_window(w);
    w = random_window();
    w[12] = '0;
    check("zero centre class", ref_result(w), {8'd0, 1'b0});
    send_window(w);
    wait_drain("directed windows");

    // random traffic at full credit rate
    for (int i = 0; i < 40; i++) begin
      if (i % 2 == 0) begin
        w = random_window();
      end else begin
        w = quadrant_window(pix_t'($random(seed)), pix_t'($random(seed)));
      end
      send_window(w);
    end
    wait_drain("random traffic");

    // back-pressure: consumer silent, producer fills the queue
    check("producer credits before back-pressure", prod_credits, DEPTH);
    consumer_on = 1'b0;
    for (int i = 0; i < DEPTH; i++) begin
      send_window(random_window());
    end
    check("producer credits used up", prod_credits, 0);
    held = received;
    repeat (12) @(posedge clk);
    #1;
    check("results held back", received, held);
    check("no credit returned while held", prod_credits, 0);
    consumer_on = 1'b1;
    wait_drain("back-pressure release");
    check("every item returned", received, sent);
    finish_run();
  end

endmodule

//--- dv/harris_props.sv
// assertions on the result queue credit protocol and its reset state
// bound into every harris_out_queue instance

module harris_props (
  input logic clk,
  input logic arst_n,
  input logic r_valid,
  input logic out_credit,
  input logic out_valid,
  input logic in_credit
);
  timeunit 1ns;
  timeprecision 100ps;

  // consumer credits and held results, tracked from the queue ports alone
  int owed;
  int held;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      owed <= 0;
      held <= 0;
    end else begin
      owed <= owed + int'(out_credit) - int'(out_valid);
      held <= held + int'(r_valid) - int'(out_valid);
    end
  end

  // a release is always paid for by a consumer credit
  release_has_credit: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> (owed != 0))
    else $error("out_valid seen with no downstream credit held");

  // one upstream credit per released result, in the same cycle
  credit_follows_release: assert property (@(posedge clk) disable iff (!arst_n)
    in_credit == (out_valid && (held != 0)))
    else $error("in_credit does not match the release of a held result");

  // queue comes out of reset empty
  quiet_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> !out_valid)
    else $error("out_valid high in the first cycle after reset");

endmodule

bind harris_out_queue harris_props i_props (
  .clk        (clk),
  .arst_n     (arst_n),
  .r_valid    (r_valid),
  .out_credit (out_credit),
  .out_valid  (out_valid),
  .in_credit  (in_credit)
);

//--- design/harris_top.sv
// top level of the streaming Harris corner classifier
// three registered stages feed a credit-controlled result queue

module harris_top #(
  parameter int THRESH = 5000,
  parameter int DEPTH  = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,
  input  harris_pix_pkg::window_t in_window,
  output logic                    in_credit,
  input  logic                    out_credit,
  output logic                    out_valid,
  output harris_pix_pkg::result_t out_result
);
  import harris_pix_pkg::*;
  import harris_math_pkg::*;

  // stage links
  logic         g_valid;
  prods_t [8:0] g_prods_arr;
  logic         g_edge;
  pix_t         g_centre;
  logic         s_valid;
  sums_t        s_sums;
  logic         s_edge;
  pix_t         s_centre;
  logic         r_valid;
  result_t      r_result;

  harris_gradient i_gradient (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_window   (in_window),
    .g_valid     (g_valid),
    .g_prods_arr (g_prods_arr),
    .g_edge      (g_edge),
    .g_centre    (g_centre)
  );

  harris_smooth i_smooth (
    .clk         (clk),
    .arst_n      (arst_n),
    .g_valid     (g_valid),
    .g_prods_arr (g_prods_arr),
    .g_edge      (g_edge),
    .g_centre    (g_centre),
    .s_valid     (s_valid),
    .s_sums      (s_sums),
    .s_edge      (s_edge),
    .s_centre    (s_centre)
  );

  harris_response #(
    .THRESH (THRESH)
  ) i_response (
    .clk      (clk),
    .arst_n   (arst_n),
    .s_valid  (s_valid),
    .s_sums   (s_sums),
    .s_edge   (s_edge),
    .s_centre (s_centre),
    .r_valid  (r_valid),
    .r_result (r_result)
  );

  harris_out_queue #(
    .DEPTH (DEPTH)
  ) i_out_queue (
    .clk        (clk),
    .arst_n     (arst_n),
    .r_valid    (r_valid),
    .r_result   (r_result),
    .out_credit (out_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .in_credit  (in_credit)
  );

endmodule

//--- design/harris_out_queue.sv
// result queue at the output of the classifier pipeline
// holds results until the consumer grants a credit, then releases them
// in order and returns one upstream credit per released slot

module harris_out_queue #(
  parameter int DEPTH = 4
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    r_valid,
  input  harris_pix_pkg::result_t r_result,
  input  logic                    out_credit,
  output logic                    out_valid,
  output harris_pix_pkg::result_t out_result,
  output logic                    in_credit
);
  import harris_pix_pkg::*;

  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = 16;

  result_t           mem [DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic [CRED_W-1:0] credits;
  logic              credit_add;
  logic              pop;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // release in the same cycle a result and a credit are both on hand
  assign pop        = (count != '0) && (credits != '0);
  assign out_valid  = pop;
  assign in_credit  = pop;
  assign out_result = mem[rd_ptr];

  // counter saturates rather than wrap on a runaway consumer
  assign credit_add = out_credit && !(&credits);

  // upstream credits guarantee a free slot for every incoming result
  always_ff @(posedge clk) begin
    if (r_valid) begin
      mem[wr_ptr] <= r_result;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= '0;
    end else begin
      if (r_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      count   <= count + CNT_W'(r_valid) - CNT_W'(pop);
      credits <= credits + CRED_W'(credit_add) - CRED_W'(pop);
    end
  end

endmodule

//--- design/harris_response.sv
// third pipeline stage of the Harris classifier
// R = Sxx*Syy - Sxy^2 - ((K_NUM*(Sxx+Syy)^2) >> K_SHIFT), then the
// edge/threshold rule picks the output pixel and the corner bit

module harris_response #(
  parameter int THRESH = 5000
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   s_valid,
  input  harris_math_pkg::sums_t s_sums,
  input  logic                   s_edge,
  input  harris_pix_pkg::pix_t   s_centre,
  output logic                   r_valid,
  output harris_pix_pkg::result_t r_result
);
  import harris_pix_pkg::*;
  import harris_math_pkg::*;

  resp_t   sxx;
  resp_t   syy;
  resp_t   sxy;
  resp_t   det;
  resp_t   trace;
  resp_t   k_term;
  resp_t   resp;
  logic    corner;
  result_t result_d;

  // ******************************
  // response
  // ******************************
  always_comb begin
    sxx    = resp_t'(s_sums.xx);
    syy    = resp_t'(s_sums.yy);
    sxy    = resp_t'(s_sums.xy);
    det    = sxx * syy - sxy * sxy;
    trace  = sxx + syy;
    // trace squared is never negative, so the shift is a plain divide
    k_term = (resp_t'(K_NUM) * trace * trace) >>> K_SHIFT;
    resp   = det - k_term;
  end

  // ******************************
  // classification
  // ******************************
  // flat area: keep the centre, no corner
  // edge above threshold: keep the centre, flag it
  // edge at or below threshold: suppress to black
  always_comb begin
    corner          = s_edge && (resp > resp_t'(THRESH));
    result_d.corner = corner;
    result_d.pixel  = (s_edge && !corner) ? '0 : s_centre;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      r_valid <= 1'b0;
    end else begin
      r_valid <= s_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (s_valid) begin
      r_result <= result_d;
    end
  end

endmodule

//--- design/harris_smooth.sv
// second pipeline stage of the Harris classifier
// 1-2-1 / 2-4-2 / 1-2-1 weighted sums of the nine product triples
// edge flag and centre pixel ride along with the sums

module harris_smooth (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          g_valid,
  input  harris_math_pkg::prods_t [8:0] g_prods_arr,
  input  logic                          g_edge,
  input  harris_pix_pkg::pix_t          g_centre,
  output logic                          s_valid,
  output harris_math_pkg::sums_t        s_sums,
  output logic                          s_edge,
  output harris_pix_pkg::pix_t          s_centre
);
  import harris_pix_pkg::*;
  import harris_math_pkg::*;

  sums_t sums_d;

  // separable weight: x2 for the middle row, x2 again for the middle column
  function automatic int wshift(input int k);
    return int'(k / 3 == 1) + int'(k % 3 == 1);
  endfunction

  function automatic sum_t weigh(input prod_t p, input int sh);
    return sum_t'(p) <<< sh;
  endfunction

  always_comb begin
    sums_d = '0;
    for (int k = 0; k < 9; k++) begin
      sums_d.xx = sums_d.xx + weigh(g_prods_arr[k].xx, wshift(k));
      sums_d.yy = sums_d.yy + weigh(g_prods_arr[k].yy, wshift(k));
      sums_d.xy = sums_d.xy + weigh(g_prods_arr[k].xy, wshift(k));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s_valid <= 1'b0;
    end else begin
      s_valid <= g_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (g_valid) begin
      s_sums   <= sums_d;
      s_edge   <= g_edge;
      s_centre <= g_centre;
    end
  end

endmodule

//--- design/harris_gradient.sv
// first pipeline stage of the Harris classifier
// Sobel Ix/Iy at the nine inner positions of a 5x5 window, their products,
// and the edge check over the centre cross; all outputs registered once

module harris_gradient (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          in_valid,
  input  harris_pix_pkg::window_t       in_window,
  output logic                          g_valid,
  output harris_math_pkg::prods_t [8:0] g_prods_arr,
  output logic                          g_edge,
  output harris_pix_pkg::pix_t          g_centre
);
  import harris_pix_pkg::*;
  import harris_math_pkg::*;

  localparam int CTR = 2 * WIN_SIZE + 2;
  // up, left, right, down from the centre
  localparam int NBR_OFS [4] = '{-WIN_SIZE, -1, 1, WIN_SIZE};

  prods_t [8:0] prods_d;
  grad_t        ix [9];
  grad_t        iy [9];
  pix_t         cross_max;
  pix_t         cross_min;
  logic         edge_d;

  // sample at (row, col), zero-extended to the gradient width
  function automatic grad_t px(input window_t w, input int row, input int col);
    return grad_t'({{(GRAD_W-PIX_W){1'b0}}, w[row*WIN_SIZE+col]});
  endfunction

  // right column minus left column, 1-2-1 weights
  function automatic grad_t sobel_x(input window_t w, input int r, input int c);
    return (px(w, r-1, c+1) + (px(w, r, c+1) <<< 1) + px(w, r+1, c+1))
         - (px(w, r-1, c-1) + (px(w, r, c-1) <<< 1) + px(w, r+1, c-1));
  endfunction

  // bottom row minus top row, 1-2-1 weights
  function automatic grad_t sobel_y(input window_t w, input int r, input int c);
    return (px(w, r+1, c-1) + (px(w, r+1, c) <<< 1) + px(w, r+1, c+1))
         - (px(w, r-1, c-1) + (px(w, r-1, c) <<< 1) + px(w, r-1, c+1));
  endfunction

  // ******************************
  // gradients and products
  // ******************************
  // inner position k sits at window row k/3+1, column k%3+1
  always_comb begin
    for (int k = 0; k < 9; k++) begin
      ix[k] = sobel_x(in_window, k / 3 + 1, k % 3 + 1);
      iy[k] = sobel_y(in_window, k / 3 + 1, k % 3 + 1);
      prods_d[k].xx = prod_t'(ix[k]) * prod_t'(ix[k]);
      prods_d[k].yy = prod_t'(iy[k]) * prod_t'(iy[k]);
      prods_d[k].xy = prod_t'(ix[k]) * prod_t'(iy[k]);
    end
  end

  // spread over the centre and its four direct neighbours
  always_comb begin
    cross_max = in_window[CTR];
    cross_min = in_window[CTR];
    for (int d = 0; d < 4; d++) begin
      if (in_window[CTR+NBR_OFS[d]] > cross_max) begin
        cross_max = in_window[CTR+NBR_OFS[d]];
      end
      if (in_window[CTR+NBR_OFS[d]] < cross_min) begin
        cross_min = in_window[CTR+NBR_OFS[d]];
      end
    end
    // a black centre never counts as an edge
    edge_d = (pix_t'(cross_max - cross_min) >= pix_t'(1)) && (in_window[CTR] != '0);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      g_valid <= 1'b0;
    end else begin
      g_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      g_prods_arr <= prods_d;
      g_edge      <= edge_d;
      g_centre    <= in_window[CTR];
    end
  end

endmodule

//--- design/harris_math_pkg.sv
// arithmetic types for the Harris response datapath
// widths cover the worst case 8-bit window without overflow
// import inside a module body; ports use scoped names

package harris_math_pkg;

  // ******************************
  // datapath widths
  // ******************************
  // |Ix| <= 4*255, product <= 1020^2, sum of 16 weighted products,
  // and the trace square scaled by K_NUM all fit with a sign bit
  localparam int GRAD_W = 11;
  localparam int PROD_W = 22;
  localparam int SUM_W  = 27;
  localparam int RESP_W = 58;

  typedef logic signed [GRAD_W-1:0] grad_t;
  typedef logic signed [PROD_W-1:0] prod_t;
  typedef logic signed [SUM_W-1:0]  sum_t;
  typedef logic signed [RESP_W-1:0] resp_t;

  // gradient products at one inner position
  typedef struct packed {
    prod_t xx;
    prod_t yy;
    prod_t xy;
  } prods_t;

  // gaussian-weighted products over the 3x3 inner grid
  typedef struct packed {
    sum_t xx;
    sum_t yy;
    sum_t xy;
  } sums_t;

  // trace factor k = K_NUM / 2^K_SHIFT, about 0.07
  localparam int K_NUM   = 18;
  localparam int K_SHIFT = 8;

endpackage

//--- design/harris_pix_pkg.sv
// pixel-side types for the Harris corner classifier
// shared by the datapath stages, the result queue and the testbench
// import inside a module body; ports use scoped names

package harris_pix_pkg;

  // ******************************
  // pixel and window geometry
  // ******************************
  localparam int PIX_W    = 8;
  localparam int WIN_SIZE = 5;

  // one unsigned grey-level sample
  typedef logic [PIX_W-1:0] pix_t;

  // 5x5 neighbourhood, row-major, index 12 is the centre pixel
  typedef pix_t [WIN_SIZE*WIN_SIZE-1:0] window_t;

  // ******************************
  // classifier output
  // ******************************

  // pixel is the centre value or 0 for a suppressed edge
  typedef struct packed {
    pix_t pixel;
    logic corner;
  } result_t;

endpackage
